// File: bank_mapper.sv
// Bank mapper for large cartridges

`timescale 1ns/100ps
`default_nettype none

`include "cart_defs.svh"

module bank_mapper (
	input  wire                              clk_sys,
	input  wire                              rst,
	input  wire                              rom_downloading,
	input  wire [`CART_VA_W:`CART_MASK_LSB]  rom_mask,
	input  wire                              page_ce_n,
	input  wire                              bus_rnw,
	input  wire [`CART_VA_W:1]               bus_va,
	input  wire [`CART_DATA_W-1:0]           bus_wdata,
	output logic [`CART_VA_W:1]              rom_va
);
	localparam int SEL_W = $clog2(`CART_NUM_BANKS);

	logic [`CART_NUM_BANKS-1:0][`CART_BANK_W-1:0] banks;

	logic                    page_ce_q;
	logic                    bank_wr;    // Page write seen, applied next edge
	logic [SEL_W-1:0]        bank_sel;
	logic [`CART_BANK_W-1:0] bank_data;
	logic                    big_rom;

	assign big_rom = |rom_mask[`CART_VA_W -: 2];  // Over 4 MB

	////////////////////////////////////////////////////////////////////////////
	// Page register strobe

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			page_ce_q <= 1'b1;
			bank_wr   <= 1'b0;
		end else begin
			page_ce_q <= page_ce_n;
			// Register 0 is not a bank
			bank_wr   <= page_ce_q && !page_ce_n && !bus_rnw && (|bus_va[SEL_W:1]);
		end
	end

	always_ff @(posedge clk_sys) begin
		bank_sel  <= bus_va[SEL_W:1];
		bank_data <= bus_wdata[`CART_BANK_W-1:0];
	end

	// Identity map until a large ROM remaps it
	always_ff @(posedge clk_sys) begin
		if (rst || rom_downloading) begin
			for (int i = 0; i < `CART_NUM_BANKS; i++)
				banks[i] <= `CART_BANK_W'(i);
		end else if (bank_wr && big_rom) begin
			banks[bank_sel] <= bank_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Banked ROM address

	// Top address bits pick a bank, then wrap to the ROM size
	assign rom_va = {banks[bus_va[21:19]], bus_va[18:1]}
		& {rom_mask, {(`CART_MASK_LSB-1){1'b1}}};

	a_banks_small_rom: assert property (@(posedge clk_sys)
		disable iff (rst || rom_downloading)
		(rom_mask[`CART_VA_W -: 2] == 2'b00) |=> $stable(banks));

endmodule

`default_nettype wire

// File: cart_defs.svh
// Cartridge loader constants

`ifndef CART_DEFS_SVH
`define CART_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Download port

`define CART_ADDR_W           25       // Byte address from host
`define CART_DATA_W           16       // One download word

// Download index decode
`define CART_IDX_ROM_MAX      6'h01    // Low six index bits, ROM loads
`define CART_IDX_CART_BIT     6        // Set for cartridge mode loads
`define CART_IDX_CHEAT        8'hFF    // Cheat code download

////////////////////////////////////////////////////////////////////////////
// ROM header and size

`define CART_HDR_REGION_ADDR  25'h1F0  // Region letter in header

// Mask covers address bits 23..13
`define CART_MASK_LSB         13

////////////////////////////////////////////////////////////////////////////
// Cartridge bus and mapper

`define CART_VA_W             23       // Word address, bits 23..1
`define CART_BANK_W           5        // 512 KB bank number
`define CART_NUM_BANKS        8

////////////////////////////////////////////////////////////////////////////
// Cheat code word offsets (byte offsets within one code)

`define CART_CHEAT_OFS_FIRST  4'h0     // Flags low word, starts a code
`define CART_CHEAT_OFS_LAST   4'hE     // Replace high word, code complete

`endif

// File: cart_loader_top.sv
// Cartridge loader top level

`timescale 1ns/100ps
`default_nettype none

`include "cart_defs.svh"

module cart_loader_top (
	input  wire                                 clk_sys,
	input  wire                                 rst,

	// Download from host
	input  wire                                 ioctl_download,
	input  wire [7:0]                           ioctl_index,
	input  wire                                 ioctl_wr,
	input  wire [`CART_ADDR_W-1:0]              ioctl_addr,
	input  wire [`CART_DATA_W-1:0]              ioctl_data,

	// Cartridge bus from console
	input  wire                                 page_ce_n,
	input  wire                                 bus_rnw,
	input  wire [`CART_VA_W:1]                  bus_va,
	input  wire [`CART_DATA_W-1:0]              bus_wdata,

	output cart_pkg::cheat_code_t               cheat_code,
	output logic                                cheat_strobe,
	output cart_pkg::region_t                   region_req,
	output logic                                region_set,
	output logic                                rom_downloading,
	output logic [`CART_VA_W:`CART_MASK_LSB]    rom_mask,
	output logic [`CART_VA_W:1]                 rom_va
);

	cheat_loader i_cheat_loader (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.cheat_code     (cheat_code),
		.cheat_strobe   (cheat_strobe)
	);

	rom_load_monitor i_rom_load_monitor (
		.clk_sys         (clk_sys),
		.rst             (rst),
		.ioctl_download  (ioctl_download),
		.ioctl_index     (ioctl_index),
		.ioctl_wr        (ioctl_wr),
		.ioctl_addr      (ioctl_addr),
		.ioctl_data      (ioctl_data),
		.rom_downloading (rom_downloading),
		.rom_mask        (rom_mask),
		.region_req      (region_req),
		.region_set      (region_set)
	);

	// Mask and load state from the monitor steer the mapper
	bank_mapper i_bank_mapper (
		.clk_sys         (clk_sys),
		.rst             (rst),
		.rom_downloading (rom_downloading),
		.rom_mask        (rom_mask),
		.page_ce_n       (page_ce_n),
		.bus_rnw         (bus_rnw),
		.bus_va          (bus_va),
		.bus_wdata       (bus_wdata),
		.rom_va          (rom_va)
	);

endmodule

`default_nettype wire

// File: cart_pkg.sv
// Cartridge loader types

`default_nettype none

`include "cart_defs.svh"

package cart_pkg;

	// One cheat code as seen by the consumer.
	// Declared MSB first, so flags sit in the lowest word pair
	typedef struct packed {
		logic [31:0] replace;  // Words 7:6
		logic [31:0] compare;  // Words 5:4
		logic [31:0] address;  // Words 3:2
		logic [31:0] flags;    // Words 1:0
	} cheat_fields_t;

	// Same 128 bits, written as download words (byte offset / 2).
	// High half of each field comes at the higher offset
	typedef union packed {
		logic [7:0][`CART_DATA_W-1:0] words;
		cheat_fields_t                fields;
	} cheat_code_t;

	// Console region as requested from the ROM header
	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

endpackage

`default_nettype wire

// File: cheat_loader.sv
// Cheat code assembler

`timescale 1ns/100ps
`default_nettype none

`include "cart_defs.svh"

module cheat_loader (
	input  wire                     clk_sys,
	input  wire                     rst,
	input  wire                     ioctl_download,
	input  wire [7:0]               ioctl_index,
	input  wire                     ioctl_wr,
	input  wire [`CART_ADDR_W-1:0]  ioctl_addr,
	input  wire [`CART_DATA_W-1:0]  ioctl_data,
	output cart_pkg::cheat_code_t   cheat_code,
	output logic                    cheat_strobe
);
	import cart_pkg::*;

	logic        code_wr;    // Word write into the current code
	cheat_code_t code_next;

	assign code_wr = ioctl_download && (ioctl_index == `CART_IDX_CHEAT) && ioctl_wr;

	// Offset 0 opens a new code, so stale flags never leak into it
	always_comb begin
		code_next = cheat_code;
		if (ioctl_addr[3:0] == `CART_CHEAT_OFS_FIRST)
			code_next.fields.flags = '0;
		code_next.words[ioctl_addr[3:1]] = ioctl_data;
	end

	always_ff @(posedge clk_sys) begin
		if (code_wr)
			cheat_code <= code_next;
	end

	// Last word written, hand the code on
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cheat_strobe <= 1'b0;
		end else begin
			cheat_strobe <= code_wr && (ioctl_addr[3:0] == `CART_CHEAT_OFS_LAST);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks

	// One code per eight-word group, never back to back
	a_strobe_single: assert property (@(posedge clk_sys) disable iff (rst)
		cheat_strobe |=> !cheat_strobe);

endmodule

`default_nettype wire

// File: rom_load_monitor.sv
// ROM download monitor

`timescale 1ns/100ps
`default_nettype none

`include "cart_defs.svh"

module rom_load_monitor (
	input  wire                                 clk_sys,
	input  wire                                 rst,
	input  wire                                 ioctl_download,
	input  wire [7:0]                           ioctl_index,
	input  wire                                 ioctl_wr,
	input  wire [`CART_ADDR_W-1:0]              ioctl_addr,
	input  wire [`CART_DATA_W-1:0]              ioctl_data,
	output logic                                rom_downloading,
	output logic [`CART_VA_W:`CART_MASK_LSB]    rom_mask,
	output cart_pkg::region_t                   region_req,
	output logic                                region_set
);
	import cart_pkg::*;

	logic old_download;
	logic dl_start;
	logic dl_end;
	logic rom_wr;

	assign rom_downloading = ioctl_download && (ioctl_index[5:0] <= `CART_IDX_ROM_MAX);

	assign dl_start = rom_downloading && !old_download;
	assign dl_end   = old_download && !rom_downloading;
	assign rom_wr   = rom_downloading && ioctl_wr;

	////////////////////////////////////////////////////////////////////////////
	// Header region letter

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			old_download <= 1'b0;
			region_req   <= REGION_JP;
			region_set   <= 1'b0;
		end else begin
			old_download <= rom_downloading;

			if (dl_start || dl_end)
				region_set <= 1'b0;  // Header state starts empty

			if (rom_wr && ioctl_addr == `CART_HDR_REGION_ADDR) begin
				region_set <= 1'b1;
				if (ioctl_data[7:0] == "U")
					region_req <= REGION_US;
				else if (ioctl_data[7:0] == "J")
					region_req <= REGION_JP;
				else
					region_req <= REGION_EU;  // Anything else plays as Europe
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// ROM size mask

	// Highest address bits seen so far give the ROM size
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			rom_mask <= '0;
		end else if (rom_wr && ioctl_index[`CART_IDX_CART_BIT]) begin
			if (ioctl_addr == '0)
				rom_mask <= '0;
			else
				rom_mask <= rom_mask | ioctl_addr[`CART_VA_W:`CART_MASK_LSB];
		end
	end

	// Region request only comes out of a header seen during a ROM load
	a_region_in_load: assert property (@(posedge clk_sys) disable iff (rst)
		$rose(region_set) |-> $past(rom_downloading));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the cartridge loader testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_cart_loader -f vlog.f || exit 1
out=$(./obj_dir/Vtb_cart_loader)
echo "$out"
echo "$out" | grep -qx "STATUS: PASS" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: stim_cart.txt
# name op a b c sel exp, hex except sel; dl a=index, wr a=addr b=data, page/probe a=addr b=wdata c=rnw
# sel: 1 rom_downloading, 2 {region_set,region_req}, 3 strobes, 4-7 cheat fields, 8 rom_va bytes, 9 rom_mask
cheat_open    dl    ff      0    0 1 0
cheat_w0      wr    0       5678 0 3 0
cheat_w1      wr    2       1234 0 3 0
cheat_w2      wr    4       bbcc 0 3 0
cheat_w3      wr    6       00aa 0 3 0
cheat_w4      wr    8       3344 0 3 0
cheat_w5      wr    a       1122 0 3 0
cheat_w6      wr    c       7788 0 3 0
cheat_w7      wr    e       5566 0 3 1
cheat_flags   probe 0       0    0 4 12345678
cheat_addr    probe 0       0    0 5 00aabbcc
cheat_cmp     probe 0       0    0 6 11223344
cheat_repl    probe 0       0    0 7 55667788
cheat_close   end   0       0    0 3 0
hdr_us_open   dl    0       0    0 1 1
hdr_us_write  wr    1f0     0055 0 2 5
hdr_us_close  end   0       0    0 2 1
hdr_jp_open   dl    0       0    0 1 1
hdr_jp_write  wr    1f0     004a 0 2 4
hdr_jp_close  end   0       0    0 2 0
hdr_eu_open   dl    1       0    0 1 1
hdr_eu_write  wr    1f0     0058 0 2 6
hdr_eu_close  end   0       0    0 2 2
cart2_open    dl    40      0    0 1 1
cart2_first   wr    0       0    0 9 0
cart2_last    wr    1ffffe  0    0 9 0ff
cart2_close   end   0       0    0 9 0ff
cart2_page    page  a130f4  9    0 8 0130f4
cart2_probe   probe 123456  0    0 8 123456
cart8_open    dl    40      0    0 1 1
cart8_first   wr    0       0    0 9 0
cart8_last    wr    7ffffe  0    0 9 3ff
cart8_close   end   0       0    0 9 3ff
cart8_page    page  a130f4  9    0 8 2130f4
cart8_probe   probe 123456  0    0 8 4a3456
read_page     page  a130f4  3    1 8 2130f4
read_probe    probe 123456  0    0 8 4a3456
reg0_page     page  a130f0  5    0 8 2130f0
reg0_probe    probe 012344  0    0 8 012344
reload_open   dl    41      0    0 1 1
reload_probe  probe 123456  0    0 8 123456
reload_close  end   0       0    0 8 123456

// File: tb_cart_loader.sv
// Cartridge loader testbench

`timescale 1ns/100ps
`default_nettype none

`include "cart_defs.svh"

module tb_cart_loader;
	localparam string STIM_FILE = "stim_cart.txt";

	logic                             clk_sys;
	logic                             rst;
	logic                             ioctl_download;
	logic [7:0]                       ioctl_index;
	logic                             ioctl_wr;
	logic [`CART_ADDR_W-1:0]          ioctl_addr;
	logic [`CART_DATA_W-1:0]          ioctl_data;
	logic                             page_ce_n;
	logic                             bus_rnw;
	logic [`CART_VA_W:1]              bus_va;
	logic [`CART_DATA_W-1:0]          bus_wdata;
	logic [127:0]                     cheat_code;
	logic                             cheat_strobe;
	logic [1:0]                       region_req;
	logic                             region_set;
	logic                             rom_downloading;
	logic [`CART_VA_W:`CART_MASK_LSB] rom_mask;
	logic [`CART_VA_W:1]              rom_va;
	int                               errors;

	string stim_q[$];
	int    num_ops = 0;
	int    bad_lines = 0;

	tb_clock_gen i_clock_gen (.*);
	cart_loader_top i_dut (.*);
	tb_checker i_checker (.*);

	task automatic load_stim();
		int    fd;
		string line;
		fd = $fopen(STIM_FILE, "r");
		if (fd != 0) begin
			while ($fgets(line, fd) > 0) begin
				if (line.len() > 1 && line.getc(0) != "#")
					stim_q.push_back(line);
			end
			$fclose(fd);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// One stim line, driven from a falling edge

	task automatic apply_line(input string line);
		string       name;
		string       op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] exp;
		int          sel;
		if ($sscanf(line, "%s %s %h %h %h %d %h", name, op, a, b, c, sel, exp) != 7) begin
			bad_lines++;
			$display("Malformed stim line: %s", line);
		end else begin
			case (op)
				"dl": begin
					ioctl_index    = a[7:0];
					ioctl_download = 1'b1;
				end
				"end": ioctl_download = 1'b0;
				"wr": begin
					ioctl_addr = a[`CART_ADDR_W-1:0];
					ioctl_data = b[`CART_DATA_W-1:0];
					ioctl_wr   = 1'b1;
					@(negedge clk_sys);
					ioctl_wr   = 1'b0;  // Single cycle strobe
				end
				"page": begin
					bus_va    = a[`CART_VA_W:1];
					bus_wdata = b[`CART_DATA_W-1:0];
					bus_rnw   = c[0];
					page_ce_n = 1'b0;
					repeat (2) @(negedge clk_sys);
					page_ce_n = 1'b1;
					bus_rnw   = 1'b1;
				end
				"probe": bus_va = a[`CART_VA_W:1];
				default: begin
					bad_lines++;
					$display("Unknown operation %s in test %s", op, name);
				end
			endcase
			i_checker.check_test(name, sel, exp);
		end
	endtask

	initial begin
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_data     = '0;
		page_ce_n      = 1'b1;
		bus_rnw        = 1'b1;
		bus_va         = '0;
		bus_wdata      = '0;
		load_stim();
		num_ops = stim_q.size();
		if (num_ops == 0) begin
			$display("No stimulus lines could be read from %s", STIM_FILE);
			$display("STATUS: FAIL");
			$finish;
		end else begin
			wait (rst === 1'b0);
			@(negedge clk_sys);
			foreach (stim_q[i])
				apply_line(stim_q[i]);
			i_checker.report_counts();
			if (errors == 0 && bad_lines == 0)
				$display("STATUS: PASS");
			else
				$display("STATUS: FAIL");
			$finish;
		end
	end

	// Watchdog, 40 cycles per stim line on top of reset
	initial begin
		wait (num_ops > 0);
		repeat (num_ops * 40 + 8) @(posedge clk_sys);
		$display("Timeout, tests did not finish within %0d cycles", num_ops * 40 + 8);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_checker.sv
// Cartridge loader output checker

`timescale 1ns/100ps
`default_nettype none

`include "cart_defs.svh"

module tb_checker (
	input  wire                              clk_sys,
	input  wire                              rst,
	input  wire [127:0]                      cheat_code,
	input  wire                              cheat_strobe,
	input  wire [1:0]                        region_req,
	input  wire                              region_set,
	input  wire                              rom_downloading,
	input  wire [`CART_VA_W:`CART_MASK_LSB]  rom_mask,
	input  wire [`CART_VA_W:1]               rom_va,
	output int                               errors
);
	int tests = 0;
	int strobes = 0;       // Cheat strobes since reset
	int strobes_seen = 0;  // Strobe count at the previous check

	initial errors = 0;

	always @(posedge clk_sys) begin
		if (!rst && cheat_strobe)
			strobes <= strobes + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Value under test, by check code

	function automatic logic [31:0] pick_actual(input int sel);
		case (sel)
			1: pick_actual = 32'(rom_downloading);
			2: pick_actual = {29'd0, region_set, region_req};
			3: pick_actual = strobes - strobes_seen;
			4: pick_actual = cheat_code[31:0];     // Flags
			5: pick_actual = cheat_code[63:32];    // Address
			6: pick_actual = cheat_code[95:64];    // Compare
			7: pick_actual = cheat_code[127:96];   // Replace
			8: pick_actual = 32'({rom_va, 1'b0});  // As byte address
			9: pick_actual = 32'(rom_mask);
			default: pick_actual = 'x;
		endcase
	endfunction

	// Outputs settle two cycles after the operation
	task automatic check_test(input string name, input int sel, input logic [31:0] exp);
		logic [31:0] act;
		repeat (2) @(negedge clk_sys);
		act = pick_actual(sel);
		tests++;
		if (sel < 1 || sel > 9) begin
			errors++;
			$display("Unknown check code %0d in test %s", sel, name);
		end else if (sel == 3 && exp != 0 && act == 0) begin
			errors++;
			$display("No cheat strobe came out in test %s", name);
		end else if (act !== exp) begin
			errors++;
			$display("Mismatch in test %s: expected %h, actual %h", name, exp, act);
		end else begin
			$display("Test %s passed", name);
		end
		strobes_seen = strobes;
	endtask

	task automatic report_counts();
		$display("Tests run: %0d, passed: %0d, failed: %0d", tests, tests - errors, errors);
	endtask

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// Testbench clock and reset

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic clk_sys,
	output logic rst
);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;  // 4 ns period
	end

	// Held for eight cycles, released on a falling edge
	initial begin
		rst = 1'b1;
		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
cart_pkg.sv
cheat_loader.sv
rom_load_monitor.sv
bank_mapper.sv
cart_loader_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_cart_loader.sv
